/* flist.f */
hdl/udp_pkg.sv
hdl/word_fifo.sv
hdl/input_arbiter.sv
hdl/output_port_lookup.sv
hdl/output_queues.sv
hdl/user_data_path.sv
testbench/tb_user_data_path.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the user data path testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_user_data_path
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module "$TOP" -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
   exit 1
fi
exit 0

/* testbench/tb_user_data_path.sv */
module tb_user_data_path;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int          NP       = 4;
   localparam int          PKTS     = 6;
   localparam int          IDLE_MAX = 100;
   localparam logic [31:0] SEED     = 32'h1c23608b;

   logic                    clk = 1'b0;
   logic                    rst;
   udp_pkg::word_t [NP-1:0] in_word;
   logic [NP-1:0]           in_wr;
   logic [NP-1:0]           in_rdy;
   udp_pkg::word_t [NP-1:0] out_word;
   logic [NP-1:0]           out_wr;
   logic [NP-1:0]           out_rdy;

   // Stimulus per phase and input, expected words per output and source
   udp_pkg::word_t stim [2][NP][$];
   udp_pkg::word_t exp_q [NP][NP][$];
   int             exp_mark [2][NP][NP];
   int             rd_idx [NP][NP];
   int             cur_src [NP];
   logic           in_pkt [NP];

   logic [31:0] rng;
   logic [31:0] rdy_rng;
   logic        started;
   logic        feeding;
   int          value_errs;
   int          proto_errs;
   int          cycle_cnt = 0;
   int          cycle_limit;

   always #2 clk = ~clk;

   user_data_path #(
      .NUM_PORTS (NP),
      .OQ_DEPTH  (16)
   ) dut0 (
      .clk      (clk),
      .rst      (rst),
      .in_word  (in_word),
      .in_wr    (in_wr),
      .in_rdy   (in_rdy),
      .out_word (out_word),
      .out_wr   (out_wr),
      .out_rdy  (out_rdy)
   );

   // ------------------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------------------

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] rand32();
      rng = xorshift32(rng);
      return rng;
   endfunction

   function automatic int rand_below(input int n);
      logic [31:0] r;
      r = rand32();
      return int'(r % 32'(n));
   endfunction

   function automatic logic is_last(input udp_pkg::word_t w);
      return (w.ctrl != udp_pkg::CTRL_MODULE_HDR) && (w.ctrl != udp_pkg::CTRL_DATA);
   endfunction

   // Expected words up to the end of phase ph not yet seen on any output
   function automatic int pending(input int ph);
      int n;
      n = 0;
      for (int o = 0; o < NP; o++) begin
         for (int s = 0; s < NP; s++) begin
            n += exp_mark[ph][o][s] - rd_idx[o][s];
         end
      end
      return n;
   endfunction

   // One packet from input src, with its expected copies on each target output
   task automatic build_packet(input int src, input int ph, input bit force_bcast);
      int                            len;
      bit                            bcast;
      int                            dport;
      logic [udp_pkg::MAX_PORTS-1:0] dst;
      udp_pkg::module_hdr_t          hdr;
      udp_pkg::dest_t                dest;
      udp_pkg::word_t                w;
      udp_pkg::word_t                pkt [$];
      len   = 3 + rand_below(6);
      bcast = force_bcast || (rand_below(4) == 0);
      dport = rand_below(16);
      dst   = '0;
      for (int i = 0; i < NP; i++) begin
         if (bcast ? (i != src) : (i == dport % NP)) begin
            dst[i] = 1'b1;
         end
      end
      hdr.dst_ports = '0;
      hdr.src_port  = 16'(src);
      hdr.pkt_words = 16'(len);
      hdr.reserved  = '0;
      w.ctrl        = udp_pkg::CTRL_MODULE_HDR;
      w.data        = hdr;
      stim[ph][src].push_back(w);
      hdr.dst_ports = dst;
      w.data        = hdr;
      pkt.push_back(w);
      for (int i = 1; i < len; i++) begin
         w.data = {rand32(), rand32()};
         w.ctrl = udp_pkg::CTRL_DATA;
         if (i == 1) begin
            dest.bcast     = bcast;
            dest.reserved  = '0;
            dest.port      = 4'(dport);
            w.data[15:0]   = dest;
         end
         if (i == len - 1) begin
            w.ctrl = udp_pkg::CTRL_WIDTH'((1 << (1 + rand_below(7))) - 1);
         end
         stim[ph][src].push_back(w);
         pkt.push_back(w);
      end
      for (int o = 0; o < NP; o++) begin
         if (dst[o]) begin
            foreach (pkt[k]) begin
               exp_q[o][src].push_back(pkt[k]);
            end
         end
      end
   endtask

   // ------------------------------------------------------------------------
   // Input feeders and output ready
   // ------------------------------------------------------------------------

   // wr only goes high in a cycle where rdy is high
   // One idle cycle follows each packet
   task automatic feed_port(input int p, input int ph);
      int             idx;
      bit             gap;
      udp_pkg::word_t w;
      idx = 0;
      gap = 1'b0;
      while (idx < stim[ph][p].size()) begin
         @(negedge clk);
         w = stim[ph][p][idx];
         if (!gap && in_rdy[p]) begin
            in_word[p] <= w;
            in_wr[p]   <= 1'b1;
            started     = 1'b1;
            idx++;
            gap = is_last(w);
         end else begin
            in_wr[p] <= 1'b0;
            gap = 1'b0;
         end
      end
      @(negedge clk);
      in_wr[p] <= 1'b0;
   endtask

   task automatic drive_rdy(input int ph);
      int idle;
      bit backpressure;
      idle         = 0;
      backpressure = (ph == 1);
      while (feeding || (pending(ph) != 0 && idle < IDLE_MAX)) begin
         @(negedge clk);
         if (backpressure) begin
            rdy_rng = xorshift32(rdy_rng);
            out_rdy <= rdy_rng[NP-1:0];
         end else begin
            out_rdy <= '1;
         end
         if (!feeding && out_wr == '0) begin
            idle++;
         end else begin
            idle = 0;
         end
      end
      out_rdy <= '1;
   endtask

   // All four inputs start together
   task automatic run_phase(input int ph);
      feeding = 1'b1;
      fork
         begin
            fork
               feed_port(0, ph);
               feed_port(1, ph);
               feed_port(2, ph);
               feed_port(3, ph);
            join
            feeding = 1'b0;
         end
         drive_rdy(ph);
      join
   endtask

   // ------------------------------------------------------------------------
   // Output checking
   // ------------------------------------------------------------------------

   always @(posedge clk) begin
      udp_pkg::word_t       w;
      udp_pkg::word_t       e;
      udp_pkg::module_hdr_t hdr;
      int                   s;
      if (rst) begin
         for (int o = 0; o < NP; o++) begin
            cur_src[o] = -1;
            in_pkt[o]  = 1'b0;
         end
      end else begin
         // Only the port holding the bus may see rdy
         assert ($onehot0(in_rdy)) else begin
            $display("More than one input was offered rdy at once (%b)", in_rdy);
            proto_errs++;
         end
         for (int o = 0; o < NP; o++) begin
            assert (started || !out_wr[o]) else begin
               $display("Output %0d wrote a word before any packet was sent", o);
               proto_errs++;
            end
            assert (!out_wr[o] || out_rdy[o]) else begin
               $display("Output %0d wrote a word while its rdy was low", o);
               proto_errs++;
            end
            if (out_wr[o]) begin
               w = out_word[o];
               if (w.ctrl == udp_pkg::CTRL_MODULE_HDR) begin
                  assert (!in_pkt[o]) else begin
                     $display("Output %0d started a packet inside another packet", o);
                     proto_errs++;
                  end
                  hdr        = udp_pkg::module_hdr_t'(w.data);
                  cur_src[o] = (hdr.src_port < 16'(NP)) ? int'(hdr.src_port) : -1;
                  in_pkt[o]  = 1'b1;
               end
               s = cur_src[o];
               if (s < 0 || rd_idx[o][s] >= exp_q[o][s].size()) begin
                  $display("ERR %0t: output %0d unexpected word %h", $time, o, w);
                  value_errs++;
               end else begin
                  e = exp_q[o][s][rd_idx[o][s]];
                  rd_idx[o][s]++;
                  assert (w == e) else begin
                     $display("ERR %0t: output %0d got %h, expected %h", $time, o, w, e);
                     value_errs++;
                  end
               end
               if (is_last(w)) begin
                  in_pkt[o] = 1'b0;
               end
            end
         end
      end
   end

   // Run length limit
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
         $display("Timeout: the run did not finish in time (%0d cycles)", cycle_limit);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   // ------------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------------

   initial begin
      int total;
      int left;
      int n;
      rst         = 1'b1;
      in_word     = '0;
      in_wr       = '0;
      out_rdy     = '1;
      started     = 1'b0;
      feeding     = 1'b0;
      value_errs  = 0;
      proto_errs  = 0;
      cycle_limit = 0;
      rng         = SEED;
      rdy_rng     = xorshift32(SEED);
      for (int o = 0; o < NP; o++) begin
         for (int s = 0; s < NP; s++) begin
            rd_idx[o][s] = 0;
         end
      end

      // Phase 0 with free outputs, phase 1 under back-pressure
      total = 0;
      for (int ph = 0; ph < 2; ph++) begin
         for (int k = 0; k < PKTS; k++) begin
            for (int p = 0; p < NP; p++) begin
               build_packet(p, ph, (ph == 0) && (k == 1));
            end
         end
         for (int p = 0; p < NP; p++) begin
            total += stim[ph][p].size();
         end
         // Scoreboard depth reached once this phase has drained
         for (int o = 0; o < NP; o++) begin
            for (int s = 0; s < NP; s++) begin
               exp_mark[ph][o][s] = exp_q[o][s].size();
            end
         end
      end
      cycle_limit = 20 * total + 200;

      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      repeat (10) @(negedge clk);

      run_phase(0);
      run_phase(1);

      left = 0;
      for (int o = 0; o < NP; o++) begin
         for (int s = 0; s < NP; s++) begin
            n = exp_q[o][s].size() - rd_idx[o][s];
            if (n > 0) begin
               $display("Output %0d is missing %0d words from input %0d", o, n, s);
               left += n;
            end
         end
      end

      $display("Errors: %0d wrong values, %0d protocol, %0d missing words",
               value_errs, proto_errs, left);
      if (value_errs == 0 && proto_errs == 0 && left == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* hdl/user_data_path.sv */
module user_data_path #(
   parameter int NUM_PORTS = 4,
   parameter int OQ_DEPTH  = 16
) (
   input  logic                           clk,
   input  logic                           rst,
   input  udp_pkg::word_t [NUM_PORTS-1:0] in_word,
   input  logic [NUM_PORTS-1:0]           in_wr,
   output logic [NUM_PORTS-1:0]           in_rdy,
   output udp_pkg::word_t [NUM_PORTS-1:0] out_word,
   output logic [NUM_PORTS-1:0]           out_wr,
   input  logic [NUM_PORTS-1:0]           out_rdy
);

   // Arbiter to lookup
   udp_pkg::word_t arb_word;
   logic           arb_wr;
   logic           arb_rdy;

   // Lookup to output queues
   udp_pkg::word_t lut_word;
   logic           lut_wr;
   logic           lut_rdy;

   // ------------------------------------------------------------------------
   // Pipeline stages
   // ------------------------------------------------------------------------

   input_arbiter #(
      .NUM_PORTS (NUM_PORTS)
   ) u_input_arbiter (
      .clk      (clk),
      .rst      (rst),
      .in_word  (in_word),
      .in_wr    (in_wr),
      .in_rdy   (in_rdy),
      .out_word (arb_word),
      .out_wr   (arb_wr),
      .out_rdy  (arb_rdy)
   );

   output_port_lookup #(
      .NUM_PORTS (NUM_PORTS)
   ) u_op_lut (
      .clk      (clk),
      .rst      (rst),
      .in_word  (arb_word),
      .in_wr    (arb_wr),
      .in_rdy   (arb_rdy),
      .out_word (lut_word),
      .out_wr   (lut_wr),
      .out_rdy  (lut_rdy)
   );

   output_queues #(
      .NUM_PORTS (NUM_PORTS),
      .OQ_DEPTH  (OQ_DEPTH)
   ) u_output_queues (
      .clk      (clk),
      .rst      (rst),
      .in_word  (lut_word),
      .in_wr    (lut_wr),
      .in_rdy   (lut_rdy),
      .out_word (out_word),
      .out_wr   (out_wr),
      .out_rdy  (out_rdy)
   );

endmodule

/* hdl/output_queues.sv */
module output_queues #(
   parameter int NUM_PORTS = 4,
   parameter int OQ_DEPTH  = 16
) (
   input  logic                           clk,
   input  logic                           rst,
   input  udp_pkg::word_t                 in_word,
   input  logic                           in_wr,
   output logic                           in_rdy,
   output udp_pkg::word_t [NUM_PORTS-1:0] out_word,
   output logic [NUM_PORTS-1:0]           out_wr,
   input  logic [NUM_PORTS-1:0]           out_rdy
);

   udp_pkg::module_hdr_t  hdr;
   logic                  is_hdr;
   logic [NUM_PORTS-1:0]  pkt_mask;
   logic [NUM_PORTS-1:0]  sel_mask;
   logic [NUM_PORTS-1:0]  full;
   logic [NUM_PORTS-1:0]  empty;
   logic                  accept;

   // ------------------------------------------------------------------------
   // Port mask
   // ------------------------------------------------------------------------

   assign hdr    = udp_pkg::module_hdr_t'(in_word.data);
   assign is_hdr = (in_word.ctrl == udp_pkg::CTRL_MODULE_HDR);

   // Header word uses its own field, the rest of the packet the latched mask
   assign sel_mask = is_hdr ? hdr.dst_ports[NUM_PORTS-1:0] : pkt_mask;

   // Stall while any selected queue is full
   assign in_rdy = ~|(sel_mask & full);
   assign accept = in_wr && in_rdy;

   always_ff @(posedge clk) begin
      if (rst) begin
         pkt_mask <= '0;
      end else if (accept && is_hdr) begin
         pkt_mask <= hdr.dst_ports[NUM_PORTS-1:0];
      end
   end

   // ------------------------------------------------------------------------
   // Per-port queues
   // ------------------------------------------------------------------------

   for (genvar i = 0; i < NUM_PORTS; i++) begin : g_queue
      word_fifo #(
         .T     (udp_pkg::word_t),
         .DEPTH (OQ_DEPTH)
      ) u_fifo (
         .clk     (clk),
         .rst     (rst),
         .wr_en   (accept && sel_mask[i]),
         .wr_data (in_word),
         .rd_en   (out_wr[i]),
         .rd_data (out_word[i]),
         .empty   (empty[i]),
         .full    (full[i])
      );

      // Drains on its own whenever the port can take a word
      assign out_wr[i] = !empty[i] && out_rdy[i];
   end

endmodule

/* hdl/output_port_lookup.sv */
module output_port_lookup #(
   parameter int NUM_PORTS = 4
) (
   input  logic           clk,
   input  logic           rst,
   input  udp_pkg::word_t in_word,
   input  logic           in_wr,
   output logic           in_rdy,
   output udp_pkg::word_t out_word,
   output logic           out_wr,
   input  logic           out_rdy
);

   localparam logic [udp_pkg::MAX_PORTS-1:0] PORT_MASK =
      udp_pkg::MAX_PORTS'((1 << NUM_PORTS) - 1);

   // Hold stage where the header waits for its first data word
   udp_pkg::word_t hold_word;
   logic           hold_vld;

   // Output register
   udp_pkg::word_t out_reg;
   logic           out_vld;

   udp_pkg::module_hdr_t            hdr;
   udp_pkg::dest_t                  dest;
   logic [udp_pkg::MAX_PORTS-1:0]   dst_ports;
   udp_pkg::word_t                  move_word;
   logic                            hold_is_hdr;
   logic                            out_space;
   logic                            in_accept;
   logic                            hold_move;

   // ------------------------------------------------------------------------
   // Destination lookup
   // ------------------------------------------------------------------------

   assign hdr  = udp_pkg::module_hdr_t'(hold_word.data);
   assign dest = udp_pkg::dest_t'(in_word.data[15:0]);

   always_comb begin
      if (dest.bcast) begin
         // Every port except the one the packet came in on
         dst_ports = PORT_MASK & ~(udp_pkg::MAX_PORTS'(1) << hdr.src_port);
      end else begin
         dst_ports = udp_pkg::MAX_PORTS'(1) << (int'(dest.port) % NUM_PORTS);
      end
   end

   always_comb begin
      move_word = hold_word;
      if (hold_is_hdr) begin
         move_word.data[63:48] = dst_ports;
      end
   end

   // ------------------------------------------------------------------------
   // Handshake
   // ------------------------------------------------------------------------

   assign hold_is_hdr = hold_vld && (hold_word.ctrl == udp_pkg::CTRL_MODULE_HDR);
   assign out_space   = !out_vld || out_rdy;
   assign in_rdy      = !hold_vld || out_space;
   assign in_accept   = in_wr && in_rdy;

   // A held header only leaves together with the arrival of its data word
   assign hold_move = hold_vld && out_space && (!hold_is_hdr || in_accept);

   assign out_word = out_reg;
   assign out_wr   = out_vld && out_rdy;

   always_ff @(posedge clk) begin
      if (rst) begin
         hold_vld <= 1'b0;
         out_vld  <= 1'b0;
      end else begin
         if (in_accept) begin
            hold_vld <= 1'b1;
         end else if (hold_move) begin
            hold_vld <= 1'b0;
         end
         if (hold_move) begin
            out_vld <= 1'b1;
         end else if (out_rdy) begin
            out_vld <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (in_accept) begin
         hold_word <= in_word;
      end
      if (hold_move) begin
         out_reg <= move_word;
      end
   end

endmodule

/* hdl/input_arbiter.sv */
module input_arbiter #(
   parameter int NUM_PORTS = 4
) (
   input  logic                           clk,
   input  logic                           rst,
   input  udp_pkg::word_t [NUM_PORTS-1:0] in_word,
   input  logic [NUM_PORTS-1:0]           in_wr,
   output logic [NUM_PORTS-1:0]           in_rdy,
   output udp_pkg::word_t                 out_word,
   output logic                           out_wr,
   input  logic                           out_rdy
);

   localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

   logic [IDX_W-1:0] ptr;
   logic [IDX_W-1:0] grant;
   logic             in_packet;
   logic [IDX_W-1:0] cand;
   logic [IDX_W-1:0] sel;
   logic             accept;
   logic             last_word;

   function automatic logic [IDX_W-1:0] next_port(input logic [IDX_W-1:0] p);
      if (p == IDX_W'(NUM_PORTS - 1)) begin
         return '0;
      end
      return p + 1'b1;
   endfunction

   // ------------------------------------------------------------------------
   // Port selection
   // ------------------------------------------------------------------------

   // First port with wr high, starting at the round-robin pointer.
   // With no request the pointer port itself is offered rdy
   always_comb begin
      int   idx;
      logic found;
      cand  = ptr;
      found = 1'b0;
      for (int i = 0; i < NUM_PORTS; i++) begin
         idx = (int'(ptr) + i) % NUM_PORTS;
         if (!found && in_wr[idx]) begin
            cand  = IDX_W'(idx);
            found = 1'b1;
         end
      end
   end

   // Grant is held for the whole packet
   assign sel = in_packet ? grant : cand;

   always_comb begin
      in_rdy      = '0;
      in_rdy[sel] = out_rdy;
   end

   assign out_word  = in_word[sel];
   assign out_wr    = in_wr[sel] & out_rdy;
   assign accept    = out_wr;
   assign last_word = (out_word.ctrl != udp_pkg::CTRL_MODULE_HDR) &&
                      (out_word.ctrl != udp_pkg::CTRL_DATA);

   // ------------------------------------------------------------------------
   // Grant and pointer state
   // ------------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         ptr       <= '0;
         grant     <= '0;
         in_packet <= 1'b0;
      end else if (accept) begin
         if (!in_packet) begin
            grant     <= sel;
            in_packet <= !last_word;
         end else if (last_word) begin
            in_packet <= 1'b0;
         end
         // Search restarts after the port that just finished
         if (last_word) begin
            ptr <= next_port(sel);
         end
      end else if (!in_packet) begin
         // Idle, so offer rdy to the next port
         ptr <= next_port(ptr);
      end
   end

endmodule

/* hdl/word_fifo.sv */
module word_fifo #(
   parameter type T     = logic [7:0],
   parameter int  DEPTH = 16
) (
   input  logic clk,
   input  logic rst,
   input  logic wr_en,
   input  T     wr_data,
   input  logic rd_en,
   output T     rd_data,
   output logic empty,
   output logic full
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   T                mem [DEPTH];
   logic [AW-1:0]   wr_ptr;
   logic [AW-1:0]   rd_ptr;
   logic [CW-1:0]   count;
   logic            do_wr;
   logic            do_rd;

   assign do_wr   = wr_en && !full;
   assign do_rd   = rd_en && !empty;
   assign empty   = (count == '0);
   assign full    = (count == CW'(DEPTH));
   assign rd_data = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Simultaneous read and write leaves the count unchanged
         if (do_wr && !do_rd) begin
            count <= count + 1'b1;
         end else if (do_rd && !do_wr) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data;
      end
   end

endmodule

/* hdl/udp_pkg.sv */
package udp_pkg;

   // ------------------------------------------------------------------------
   // Bus widths
   // ------------------------------------------------------------------------

   localparam int DATA_WIDTH = 64;
   localparam int CTRL_WIDTH = DATA_WIDTH / 8;

   // Width of the destination port field in the module header
   localparam int MAX_PORTS = 16;

   // ------------------------------------------------------------------------
   // Control codes
   // ------------------------------------------------------------------------

   // Marks the module header word
   localparam logic [CTRL_WIDTH-1:0] CTRL_MODULE_HDR = 8'hFF;

   // Marks a header-following or middle word, any other value ends the packet
   localparam logic [CTRL_WIDTH-1:0] CTRL_DATA = '0;

   // ------------------------------------------------------------------------
   // Word formats
   // ------------------------------------------------------------------------

   // One word on the pipeline bus
   typedef struct packed {
      logic [CTRL_WIDTH-1:0] ctrl;
      logic [DATA_WIDTH-1:0] data;
   } word_t;

   // Data field of the module header word
   typedef struct packed {
      logic [MAX_PORTS-1:0] dst_ports;
      logic [15:0]          src_port;
      logic [15:0]          pkt_words;
      logic [15:0]          reserved;
   } module_hdr_t;

   // Low 16 bits of the first data word
   typedef struct packed {
      logic        bcast;
      logic [10:0] reserved;
      logic [3:0]  port;
   } dest_t;

endpackage
